//--- verification/runaheadCases.txt
# op dest a b (hex; a and b form the immediate of a load) miss delay sync order
# sync waits for memory to go idle first, order is the position on exec.
# Clean instructions with no miss pending.
8 1 0 5 0 0 0 0
0 2 1 1 0 0 0 1
1 3 2 1 0 0 0 2
# Missed load on r4 with a dependent chain and independent work between.
9 4 1 0 1 14 1 3
0 5 4 2 0 0 0 7
3 6 3 1 0 0 0 4
4 7 5 3 0 0 0 8
2 8 2 2 0 0 0 5
5 9 7 4 0 0 0 9
8 a 3 c 0 0 0 6
# Eight dependents fill the queue.
9 b 0 0 1 20 1 10
0 c b 0 0 0 0 11
0 d c 0 0 0 0 12
0 e d 0 0 0 0 13
0 f e 0 0 0 0 14
1 1 b 0 0 0 0 15
1 2 1 0 0 0 0 16
3 3 c 0 0 0 0 17
4 5 f 0 0 0 0 18
0 6 b 1 0 0 0 19
5 7 5 3 0 0 0 20

//--- filelist.f
hdl/runaheadPkg.sv
hdl/operandValidation.sv
hdl/dirtyScoreboard.sv
hdl/runaheadQueue.sv
hdl/runaheadControl.sv
hdl/missTimer.sv
hdl/runaheadCore.sv
verification/runaheadCore_props.sv
verification/runaheadCoreTb.sv

//--- verification/runaheadCoreTb.sv
module runaheadCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    import runaheadPkg::*;

    localparam int ClkPeriod = 4;

    typedef struct packed {
        logic [3:0] op;
        logic [3:0] dest;
        logic [3:0] a;
        logic [3:0] b;
        logic       miss;
        logic [7:0] delay;
        logic       sync;
        logic [7:0] order;
    } CaseLine;

    logic                    clk;
    logic                    rstN;
    IssueBeat                issue;
    logic                    issueReady;
    ExecBeat                 exec;
    logic                    memReq;
    logic [RegAddrWidth-1:0] memDest;
    logic                    memAck;
    logic [TimerWidth-1:0]   lastMissLatency;

    CaseLine cases[$];
    ExecBeat expected[$];
    int      expDelays[$];
    logic [RegAddrWidth-1:0] expDests[$];
    int      heldIdx[$];
    logic [RegCount-1:0] modelDirty;
    logic    modelPending;
    int      execCount;
    int      cycleLimit;
    logic    limitReady;

    runaheadCore UUT (
        .clk(clk), .rstN(rstN), .issue(issue), .issueReady(issueReady),
        .exec(exec), .memReq(memReq), .memDest(memDest), .memAck(memAck),
        .lastMissLatency(lastMissLatency)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic stopWithFailure();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic checkExec(string name, ExecBeat got, ExecBeat exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkLatency(string name, logic [TimerWidth-1:0] got,
                                logic [TimerWidth-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkDest(string name, logic [RegAddrWidth-1:0] got,
                             logic [RegAddrWidth-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkReady(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
            stopWithFailure();
        end
    endtask

    function automatic InstrWord wordOf(CaseLine c);
        return {c.op, c.dest, c.a, c.b};
    endfunction

    task automatic readCases();
        int      fd;
        int      n;
        int      f[8];
        string   line;
        CaseLine c;
        fd = $fopen("verification/runaheadCases.txt", "r");
        if (fd == 0) begin
            $display("The case file could not be opened.");
            stopWithFailure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            if (n != 8) begin
                continue;
            end
            c = {f[0][3:0], f[1][3:0], f[2][3:0], f[3][3:0], f[4][0],
                 f[5][7:0], f[6][0], f[7][7:0]};
            cases.push_back(c);
        end
        $fclose(fd);
    endtask

    // The sequence number in the case file must agree with the model.
    task automatic addExpected(int idx, logic replayed);
        if (cases[idx].order != expected.size()) begin
            $display("Case line %0d expects position %0d, the model gives %0d.",
                     idx, cases[idx].order, expected.size());
            stopWithFailure();
        end
        expected.push_back({1'b1, wordOf(cases[idx]), replayed});
    endtask

    // Load data is back, so the queue drains in order and every bit clears.
    task automatic replayHeld();
        while (heldIdx.size() > 0) begin
            addExpected(heldIdx.pop_front(), 1'b1);
        end
        modelDirty = '0;
        modelPending = 1'b0;
    endtask

    task automatic buildExpected();
        CaseLine c;
        logic    usesA;
        logic    usesB;
        modelDirty = '0;
        modelPending = 1'b0;
        foreach (cases[i]) begin
            c = cases[i];
            if (c.sync && modelPending) begin
                replayHeld();
            end
            // Immediate loads read nothing, loads read only the base register.
            usesA = (c.op != 4'h8);
            usesB = (c.op < 4'h8);
            if (modelPending && ((usesA && modelDirty[c.a]) || (usesB && modelDirty[c.b]))) begin
                heldIdx.push_back(i);
                modelDirty[c.dest] = 1'b1;
                if (heldIdx.size() == QueueDepth) begin
                    replayHeld();
                end
            end else begin
                addExpected(i, 1'b0);
                if (!modelPending && c.miss && (c.op == 4'h9)) begin
                    modelPending = 1'b1;
                    modelDirty[c.dest] = 1'b1;
                    expDelays.push_back(c.delay);
                    expDests.push_back(c.dest);
                end
            end
        end
        replayHeld();
    endtask

    task automatic waitMemoryIdle();
        issue <= '0;
        repeat (2) @(posedge clk);
        while (memReq || memAck) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // Memory responder for the four-phase channel.
    initial begin
        int delay;
        wait (rstN === 1'b1);
        forever begin
            @(posedge clk);
            if (memReq && !memAck) begin
                if (expDelays.size() == 0) begin
                    $display("A memory request came that no missed load explains.");
                    stopWithFailure();
                end
                delay = expDelays.pop_front();
                checkDest("memDest", memDest, expDests.pop_front());
                // The edge that saw memReq already counts as one.
                repeat (delay - 1) @(posedge clk);
                memAck <= 1'b1;
                @(posedge clk);
                while (memReq) begin
                    @(posedge clk);
                end
                memAck <= 1'b0;
                checkLatency("lastMissLatency", lastMissLatency, delay);
            end
        end
    end

    initial begin
        logic lastReplay;
        wait (rstN === 1'b1);
        forever begin
            @(posedge clk);
            if (exec.valid) begin
                if (execCount >= expected.size()) begin
                    $display("exec produced a beat beyond the expected sequence.");
                    stopWithFailure();
                end
                checkExec("exec", exec, expected[execCount]);
                // Issue stays stalled until the last queued entry has gone out.
                if (expected[execCount].replayed) begin
                    lastReplay = (execCount + 1 == expected.size()) ||
                                 !expected[execCount + 1].replayed;
                    checkReady("issueReady", issueReady, lastReplay);
                end
                execCount++;
            end
        end
    end

    initial begin
        wait (limitReady === 1'b1);
        #(cycleLimit * ClkPeriod);
        $display("exec stopped advancing after %0d of %0d beats.", execCount, expected.size());
        stopWithFailure();
    end

    initial begin
        int maxDelay;
        rstN = 1'b0;
        issue = '0;
        memAck = 1'b0;
        execCount = 0;
        limitReady = 1'b0;
        maxDelay = 0;
        readCases();
        buildExpected();
        foreach (cases[i]) begin
            if (cases[i].delay > maxDelay) begin
                maxDelay = cases[i].delay;
            end
        end
        cycleLimit = cases.size() * (maxDelay + 10);
        limitReady = 1'b1;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        foreach (cases[i]) begin
            if (cases[i].sync) begin
                waitMemoryIdle();
            end
            issue <= {1'b1, wordOf(cases[i]), cases[i].miss};
            @(posedge clk);
            while (!issueReady) begin
                @(posedge clk);
            end
        end
        issue <= '0;
        while (execCount < expected.size()) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- verification/runaheadCore_props.sv
module runaheadCoreProps (
    input logic                                 clk,
    input logic                                 rstN,
    input logic                                 memReq,
    input logic                                 memAck,
    input logic [runaheadPkg::RegAddrWidth-1:0] memDest,
    input logic                                 issueReady,
    input runaheadPkg::CtrlState                state,
    input logic                                 push,
    input logic                                 pop,
    input logic                                 full,
    input logic                                 empty
);
    timeunit 1ns;
    timeprecision 100ps;

    import runaheadPkg::*;

    // A request may only drop after the responder has answered.
    reqHeld: assert property (@(posedge clk) disable iff (!rstN)
        memReq && !memAck |=> memReq)
        else $error("memReq dropped before memAck rose");

    destStable: assert property (@(posedge clk) disable iff (!rstN)
        memReq && $past(memReq) |-> $stable(memDest))
        else $error("memDest changed during a memory request");

    // Issue only reopens once the queue has drained.
    replayStall: assert property (@(posedge clk) disable iff (!rstN)
        (state == StReplay) && !empty |-> !issueReady)
        else $error("issueReady high while replaying");

    noPushFull: assert property (@(posedge clk) disable iff (!rstN)
        !(push && full))
        else $error("push into a full queue");

    noPopEmpty: assert property (@(posedge clk) disable iff (!rstN)
        !(pop && empty))
        else $error("pop from an empty queue");

endmodule

bind runaheadCore runaheadCoreProps props (
    .clk(clk), .rstN(rstN), .memReq(memReq), .memAck(memAck),
    .memDest(memDest), .issueReady(issueReady), .state(control.state),
    .push(defer), .pop(pop), .full(full), .empty(empty)
);

//--- hdl/runaheadCore.sv
module runaheadCore (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  runaheadPkg::IssueBeat                 issue,
    output logic                                 issueReady,
    output runaheadPkg::ExecBeat                  exec,
    output logic                                 memReq,
    output logic [runaheadPkg::RegAddrWidth-1:0] memDest,
    input  logic                                 memAck,
    output logic [runaheadPkg::TimerWidth-1:0]   lastMissLatency
);
    import runaheadPkg::*;

    OperandStatus            statusA;
    OperandStatus            statusB;
    WriteBack                writeBack;
    InstrWord                pushWord;
    InstrWord                popWord;
    logic                    accepted;
    logic                    defer;
    logic                    full;
    logic                    empty;
    logic                    pop;
    logic                    setValid;
    logic [RegAddrWidth-1:0] setDest;
    logic                    clearValid;
    logic [RegAddrWidth-1:0] clearDest;

    dirtyScoreboard scoreboard (
        .clk(clk), .rstN(rstN), .issue(issue), .accepted(accepted),
        .setValid(setValid), .setDest(setDest),
        .clearValid(clearValid), .clearDest(clearDest),
        .statusA(statusA), .statusB(statusB)
    );

    operandValidation validation (
        .clk(clk), .rstN(rstN), .issue(issue), .accepted(accepted),
        .statusA(statusA), .statusB(statusB), .writeBack(writeBack),
        .defer(defer), .pushWord(pushWord)
    );

    // Deferred beats are pushed in the cycle they are accepted.
    runaheadQueue queue (
        .clk(clk), .rstN(rstN), .push(defer), .pushWord(pushWord),
        .pop(pop), .popWord(popWord), .full(full), .empty(empty)
    );

    runaheadControl control (
        .clk(clk), .rstN(rstN), .issue(issue), .defer(defer),
        .full(full), .empty(empty), .popWord(popWord), .memAck(memAck),
        .memReq(memReq), .memDest(memDest), .issueReady(issueReady),
        .accepted(accepted), .writeBack(writeBack),
        .setValid(setValid), .setDest(setDest),
        .clearValid(clearValid), .clearDest(clearDest),
        .pop(pop), .exec(exec)
    );

    missTimer timer (
        .clk(clk), .rstN(rstN), .memReq(memReq), .memAck(memAck),
        .lastMissLatency(lastMissLatency)
    );

endmodule

//--- hdl/missTimer.sv
module missTimer (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               memReq,
    input  logic                               memAck,
    output logic [runaheadPkg::TimerWidth-1:0] lastMissLatency
);
    import runaheadPkg::*;

    logic [TimerWidth-1:0] count;
    logic                  reqDly;
    logic                  ackDly;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            reqDly <= 1'b0;
            ackDly <= 1'b0;
            lastMissLatency <= '0;
        end else begin
            reqDly <= memReq;
            ackDly <= memAck;
            // A new request restarts the count with its first edge.
            if (memReq && !reqDly) begin
                count <= TimerWidth'(1);
            end else if (memReq && !memAck && (count != {TimerWidth{1'b1}})) begin
                count <= count + 1'b1;
            end
            if (memAck && !ackDly) begin
                lastMissLatency <= count;
            end
        end
    end

endmodule

//--- hdl/runaheadControl.sv
module runaheadControl (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  runaheadPkg::IssueBeat                 issue,
    input  logic                                 defer,
    input  logic                                 full,
    input  logic                                 empty,
    input  runaheadPkg::InstrWord                 popWord,
    input  logic                                 memAck,
    output logic                                 memReq,
    output logic [runaheadPkg::RegAddrWidth-1:0] memDest,
    output logic                                 issueReady,
    output logic                                 accepted,
    output runaheadPkg::WriteBack                 writeBack,
    output logic                                 setValid,
    output logic [runaheadPkg::RegAddrWidth-1:0] setDest,
    output logic                                 clearValid,
    output logic [runaheadPkg::RegAddrWidth-1:0] clearDest,
    output logic                                 pop,
    output runaheadPkg::ExecBeat                  exec
);
    import runaheadPkg::*;

    CtrlState state;
    CtrlState nextState;

    logic [RegAddrWidth-1:0] loadDest;
    logic                    openState;
    logic                    startMiss;
    logic                    execValid;
    logic                    execReplayed;
    InstrWord                execWord;

    // The cycle after the last pop behaves like Normal so issue resumes at once.
    assign openState = (state == StNormal) || ((state == StReplay) && empty);
    assign issueReady = !full && (openState || (state == StMissWait));
    assign accepted = issue.valid && issueReady;

    assign startMiss = accepted && openState && issue.miss && !defer &&
                       (issue.word.r.op == OpLoad);

    assign pop = (state == StReplay) && !empty;

    assign writeBack.valid = (state == StWriteBack);
    assign writeBack.dest = loadDest;

    // Deferred beats poison their own destination while the miss is out.
    assign setValid = startMiss || (accepted && defer && (state == StMissWait));
    assign setDest = issue.word.r.dest;
    assign clearValid = (state == StWriteBack) || pop;
    assign clearDest = pop ? popWord.r.dest : loadDest;

    assign memDest = loadDest;

    always_comb begin
        nextState = state;
        case (state)
            StNormal: begin
                if (startMiss) begin
                    nextState = StMissWait;
                end
            end
            StMissWait: begin
                // Done once both halves of the handshake are back low.
                if (!memReq && !memAck) begin
                    nextState = StWriteBack;
                end
            end
            StWriteBack: begin
                nextState = StReplay;
            end
            default: begin
                if (empty) begin
                    nextState = startMiss ? StMissWait : StNormal;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= StNormal;
            memReq <= 1'b0;
        end else begin
            state <= nextState;
            if (startMiss) begin
                memReq <= 1'b1;
            end else if (memReq && memAck) begin
                memReq <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startMiss) begin
            loadDest <= issue.word.r.dest;
        end
    end

    // Replayed entries and clean issued beats never collide.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            execValid <= 1'b0;
            execReplayed <= 1'b0;
        end else begin
            execValid <= pop || (accepted && !defer);
            execReplayed <= pop;
        end
    end

    always_ff @(posedge clk) begin
        execWord <= pop ? popWord : issue.word;
    end

    assign exec.valid = execValid;
    assign exec.word = execWord;
    assign exec.replayed = execReplayed;

endmodule

//--- hdl/runaheadQueue.sv
module runaheadQueue (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 push,
    input  runaheadPkg::InstrWord pushWord,
    input  logic                 pop,
    output runaheadPkg::InstrWord popWord,
    output logic                 full,
    output logic                 empty
);
    import runaheadPkg::*;

    InstrWord entries [QueueDepth];

    logic [PtrWidth-1:0] rdPtr;
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth:0]   count;

    assign popWord = entries[rdPtr];
    assign full = (count == (PtrWidth + 1)'(QueueDepth));
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= pushWord;
        end
    end

    // Depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
        end else if (push) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdPtr <= '0;
        end else if (pop) begin
            rdPtr <= rdPtr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

//--- hdl/dirtyScoreboard.sv
module dirtyScoreboard (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  runaheadPkg::IssueBeat                 issue,
    input  logic                                 accepted,
    input  logic                                 setValid,
    input  logic [runaheadPkg::RegAddrWidth-1:0] setDest,
    input  logic                                 clearValid,
    input  logic [runaheadPkg::RegAddrWidth-1:0] clearDest,
    output runaheadPkg::OperandStatus             statusA,
    output runaheadPkg::OperandStatus             statusB
);
    import runaheadPkg::*;

    logic [RegCount-1:0]     dirtyBits;
    logic [RegCount-1:0]     dirtyNext;
    logic [RegAddrWidth-1:0] prevDest [2];
    logic [1:0]              prevValid;

    function automatic OperandStatus statusFor(logic used, logic [RegAddrWidth-1:0] src);
        OperandStatus s;
        s.used  = used;
        s.dirty = dirtyBits[src];
        s.fwd1  = used && prevValid[0] && (prevDest[0] == src);
        s.fwd2  = used && prevValid[1] && (prevDest[1] == src);
        return s;
    endfunction

    // Status follows the dirty bits even while the same beat is held.
    always_comb begin
        statusA = statusFor(readsA(issue.word), srcAOf(issue.word));
        statusB = statusFor(readsB(issue.word), srcBOf(issue.word));
    end

    // Clear is applied last so that it wins over a set to the same register.
    always_comb begin
        dirtyNext = dirtyBits;
        if (setValid) begin
            dirtyNext[setDest] = 1'b1;
        end
        if (clearValid) begin
            dirtyNext[clearDest] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dirtyBits <= '0;
            prevValid <= '0;
        end else begin
            dirtyBits <= dirtyNext;
            prevValid <= {prevValid[0], accepted};
        end
    end

    // Destinations of the last two cycles for the forwarding window.
    always_ff @(posedge clk) begin
        prevDest[0] <= issue.word.r.dest;
        prevDest[1] <= prevDest[0];
    end

endmodule

//--- hdl/operandValidation.sv
module operandValidation (
    input  logic                     clk,
    input  logic                     rstN,
    input  runaheadPkg::IssueBeat     issue,
    input  logic                     accepted,
    input  runaheadPkg::OperandStatus statusA,
    input  runaheadPkg::OperandStatus statusB,
    input  runaheadPkg::WriteBack     writeBack,
    output logic                     defer,
    output runaheadPkg::InstrWord     pushWord
);
    import runaheadPkg::*;

    // Bit 0 is the previous cycle, bit 1 the cycle before that.
    logic [1:0] deferHistory;

    logic                    wbMatchA;
    logic                    wbMatchB;
    logic                    fwdDirtyA;
    logic                    fwdDirtyB;
    logic                    dirtyA;
    logic                    dirtyB;
    logic [RegAddrWidth-1:0] regA;
    logic [RegAddrWidth-1:0] regB;

    assign regA = srcAOf(issue.word);
    assign regB = srcBOf(issue.word);

    // Load data landing this cycle makes the register clean already.
    assign wbMatchA = writeBack.valid && (writeBack.dest == regA);
    assign wbMatchB = writeBack.valid && (writeBack.dest == regB);

    // A forwarded value is only dirty if its producer was deferred.
    assign fwdDirtyA = (statusA.fwd1 && deferHistory[0]) ||
                       (statusA.fwd2 && deferHistory[1]);
    assign fwdDirtyB = (statusB.fwd1 && deferHistory[0]) ||
                       (statusB.fwd2 && deferHistory[1]);

    assign dirtyA = statusA.used && (statusA.dirty || fwdDirtyA) && !wbMatchA;
    assign dirtyB = statusB.used && (statusB.dirty || fwdDirtyB) && !wbMatchB;

    assign defer = accepted && (dirtyA || dirtyB);
    assign pushWord = issue.word;

    // The window moves every cycle, so idle cycles age producers out.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            deferHistory <= '0;
        end else begin
            deferHistory <= {deferHistory[0], defer};
        end
    end

endmodule

//--- hdl/runaheadPkg.sv
package runaheadPkg;

    localparam int RegCount = 16;
    localparam int RegAddrWidth = $clog2(RegCount);
    localparam int QueueDepth = 8;
    localparam int PtrWidth = $clog2(QueueDepth);
    localparam int TimerWidth = 8;

    // ALU operations use the register format, the two loads use the immediate format.
    typedef enum logic [3:0] {
        OpAdd     = 4'h0,
        OpSub     = 4'h1,
        OpAnd     = 4'h2,
        OpOr      = 4'h3,
        OpXor     = 4'h4,
        OpShl     = 4'h5,
        OpLoadImm = 4'h8,
        OpLoad    = 4'h9
    } Opcode;

    typedef struct packed {
        Opcode                   op;
        logic [RegAddrWidth-1:0] dest;
        logic [RegAddrWidth-1:0] srcA;
        logic [RegAddrWidth-1:0] srcB;
    } RegFormat;

    typedef struct packed {
        Opcode                   op;
        logic [RegAddrWidth-1:0] dest;
        logic [7:0]              imm;
    } ImmFormat;

    typedef union packed {
        RegFormat r;
        ImmFormat i;
    } InstrWord;

    typedef struct packed {
        logic     valid;
        InstrWord word;
        logic     miss;
    } IssueBeat;

    typedef struct packed {
        logic     valid;
        InstrWord word;
        logic     replayed;
    } ExecBeat;

    // fwd1 and fwd2 match the destinations one and two cycles back.
    typedef struct packed {
        logic used;
        logic dirty;
        logic fwd1;
        logic fwd2;
    } OperandStatus;

    typedef struct packed {
        logic                    valid;
        logic [RegAddrWidth-1:0] dest;
    } WriteBack;

    typedef enum logic [1:0] {
        StNormal,
        StMissWait,
        StWriteBack,
        StReplay
    } CtrlState;

    function automatic logic readsA(InstrWord w);
        return w.r.op != OpLoadImm;
    endfunction

    function automatic logic readsB(InstrWord w);
        return (w.r.op != OpLoadImm) && (w.r.op != OpLoad);
    endfunction

    // A load takes its address base from the upper immediate nibble.
    function automatic logic [RegAddrWidth-1:0] srcAOf(InstrWord w);
        return (w.i.op == OpLoad) ? w.i.imm[7:4] : w.r.srcA;
    endfunction

    function automatic logic [RegAddrWidth-1:0] srcBOf(InstrWord w);
        return w.r.srcB;
    endfunction

endpackage
